// ==== branch_pkg.sv ====
// ========================================
// branch package
// operator, prediction and exception types
// ========================================

package branch_pkg;

    // data and address width of the core
    localparam int unsigned XLEN = 64;

    // branch and jump operators
    // anything outside the compare set resolves as an unconditional jump
    typedef enum logic [2:0] {
        EQ   = 3'd0,
        NE   = 3'd1,
        LTS  = 3'd2,
        GES  = 3'd3,
        LTU  = 3'd4,
        GEU  = 3'd5,
        JALR = 3'd6
    } fu_op;

    // exception cause codes, full register width
    typedef logic [XLEN-1:0] exc_cause;

    // branch or jump target not on a 2 byte boundary
    localparam exc_cause INSTR_ADDR_MISALIGNED = 64'd0;
    // fetch from a protected or absent region
    localparam exc_cause INSTR_ACCESS_FAULT    = 64'd1;
    // undecodable instruction word
    localparam exc_cause ILLEGAL_INSTR         = 64'd2;
    // ebreak or debug trigger
    localparam exc_cause BREAKPOINT            = 64'd3;

    // prediction that travels with a branch from fetch
    typedef struct packed {
        // the predictor recognised this pc as a branch
        logic            valid;
        // target the front end already jumped to
        logic [XLEN-1:0] predict_address;
        // predicted direction
        logic            predict_taken;
    } branchpredict_sbe;

    // resolved outcome of a branch
    typedef struct packed {
        // pc used to index the target buffer
        logic [XLEN-1:0] pc;
        // address execution continues at
        logic [XLEN-1:0] target_address;
        logic            valid;
        logic            is_taken;
        // front end has to be redirected
        logic            is_mispredict;
        // branch sits in the lower half of its fetch word
        logic            is_lower_16;
    } branchpredict;

    // exception raised by a functional unit
    typedef struct packed {
        exc_cause        cause;
        // faulting value, here the branch pc
        logic [XLEN-1:0] tval;
        logic            valid;
    } exception;

endpackage

// ==== btb_if.sv ====
// ========================================
// branch target buffer link
// lookup, prediction and update signals
// ========================================

`timescale 1ns/1ps

interface btb_if;

    // pc looked up combinationally
    logic [branch_pkg::XLEN-1:0]  lookup_pc;
    // prediction returned for lookup_pc
    branch_pkg::branchpredict_sbe predict;

    // one-cycle update strobe and its payload
    logic                         update_valid;
    logic [branch_pkg::XLEN-1:0]  update_pc;
    logic [branch_pkg::XLEN-1:0]  update_target;
    // taken writes the entry, not taken clears it
    logic                         update_taken;

    // branch unit side
    modport unit (
        output lookup_pc,
        input  predict,
        output update_valid,
        output update_pc,
        output update_target,
        output update_taken
    );

    // target buffer side
    modport buffer (
        input  lookup_pc,
        output predict,
        input  update_valid,
        input  update_pc,
        input  update_target,
        input  update_taken
    );

endinterface

// ==== branch_unit.sv ====
// ========================================
// branch unit
// compares operands and resolves targets
// ========================================

`timescale 1ns/1ps

module branch_unit (
    // only samples the checks below
    input  logic                          clk_i,
    input  branch_pkg::fu_op              operator_i,
    input  logic [branch_pkg::XLEN-1:0]   operand_a_i,
    input  logic [branch_pkg::XLEN-1:0]   operand_b_i,
    input  logic [branch_pkg::XLEN-1:0]   operand_c_i,
    input  logic [branch_pkg::XLEN-1:0]   imm_i,
    input  logic [branch_pkg::XLEN-1:0]   pc_i,
    input  logic                          is_compressed_instr_i,
    // some unit got an instruction this cycle
    input  logic                          fu_valid_i,
    // the instruction is a branch or jump
    input  logic                          valid_i,
    output branch_pkg::branchpredict      resolved_branch_o,
    output logic                          resolve_branch_o,
    output branch_pkg::exception          branch_ex_o,
    btb_if.unit                           btb
);

    localparam int unsigned XLEN = branch_pkg::XLEN;

    logic [XLEN-1:0] target_address;
    logic [XLEN-1:0] next_pc;
    // pc the buffer entry is kept under
    logic [XLEN-1:0] adjusted_pc;
    logic            comparison_result;
    logic            sgn;
    logic            less;

    // sign extension is switched off for the unsigned compares
    assign sgn  = !(operator_i inside {branch_pkg::LTU, branch_pkg::GEU});
    assign less = $signed({sgn & operand_a_i[XLEN-1], operand_a_i}) <
                  $signed({sgn & operand_b_i[XLEN-1], operand_b_i});

    always_comb begin : compare
        // jumps are always taken
        case (operator_i)
            branch_pkg::EQ:  comparison_result = (operand_a_i == operand_b_i);
            branch_pkg::NE:  comparison_result = (operand_a_i != operand_b_i);
            branch_pkg::LTS,
            branch_pkg::LTU: comparison_result = less;
            branch_pkg::GES,
            branch_pkg::GEU: comparison_result = !less;
            default:         comparison_result = 1'b1;
        endcase
    end

    // plain wrap-around add covers both signs of the immediate
    assign target_address = operand_c_i + imm_i;
    assign next_pc        = pc_i + (is_compressed_instr_i ? 64'h2 : 64'h4);

    // an uncompressed branch starting at halfword 1 straddles two words
    // so its prediction lives on the next word where fetch sees its tail
    assign adjusted_pc = (is_compressed_instr_i || !pc_i[1]) ? pc_i
                                                             : ({pc_i[XLEN-1:2], 2'b00} + 64'h4);

    // lookup with the adjusted pc only for real branches
    assign btb.lookup_pc = valid_i ? adjusted_pc : pc_i;

    always_comb begin : resolve
        resolved_branch_o.pc             = '0;
        resolved_branch_o.target_address = '0;
        resolved_branch_o.valid          = valid_i;
        resolved_branch_o.is_taken       = 1'b0;
        resolved_branch_o.is_mispredict  = 1'b0;
        resolved_branch_o.is_lower_16    = 1'b0;

        if (valid_i) begin
            resolved_branch_o.pc             = adjusted_pc;
            resolved_branch_o.is_lower_16    = (is_compressed_instr_i && !pc_i[1]) ||
                                               (!is_compressed_instr_i && pc_i[1]);
            resolved_branch_o.target_address = comparison_result ? target_address : next_pc;
            resolved_branch_o.is_taken       = comparison_result;
            // odd targets go out as an exception instead
            if (!target_address[0]) begin
                if (!btb.predict.valid ||
                    btb.predict.predict_taken != comparison_result ||
                    btb.predict.predict_address != target_address) begin
                    resolved_branch_o.is_mispredict = 1'b1;
                end
            end
        end else if (fu_valid_i && btb.predict.valid) begin
            // predictor saw a branch where there is none
            // so fetch resumes right after this instruction
            resolved_branch_o.is_mispredict  = 1'b1;
            resolved_branch_o.target_address = next_pc;
        end
    end

    // tells issue the branch has left the unit
    assign resolve_branch_o = valid_i;

    always_comb begin : misaligned
        branch_ex_o.cause = branch_pkg::INSTR_ADDR_MISALIGNED;
        branch_ex_o.tval  = pc_i;
        branch_ex_o.valid = valid_i && target_address[0];
    end

    // correct the buffer on every mispredict
    assign btb.update_valid  = resolved_branch_o.is_mispredict;
    assign btb.update_pc     = valid_i ? adjusted_pc : pc_i;
    assign btb.update_target = target_address;
    // non-branch hits drop the entry
    assign btb.update_taken  = valid_i && comparison_result;

    // a redirect and a trap never leave together
    assert property (@(posedge clk_i)
        !(resolved_branch_o.is_mispredict && branch_ex_o.valid))
    else $error("branch unit flagged mispredict together with exception");

    // the buffer only changes on a redirect
    assert property (@(posedge clk_i)
        btb.update_valid |-> resolved_branch_o.is_mispredict)
    else $error("buffer update without mispredict");

endmodule

// ==== branch_target_buffer.sv ====
// ========================================
// branch target buffer
// direct-mapped table of taken targets
// ========================================

`timescale 1ns/1ps

module branch_target_buffer #(
    // power of two, at least 2
    parameter int unsigned NR_ENTRIES = 16
) (
    input  logic  clk_i,
    input  logic  arst_n_i,
    btb_if.buffer btb
);

    localparam int unsigned XLEN  = branch_pkg::XLEN;
    localparam int unsigned IDX_W = $clog2(NR_ENTRIES);

    // per-entry state
    logic [NR_ENTRIES-1:0] valid_q;
    logic [XLEN-1:0]       tag_q    [NR_ENTRIES];
    logic [XLEN-1:0]       target_q [NR_ENTRIES];

    logic [IDX_W-1:0]      lookup_idx;
    logic [IDX_W-1:0]      update_idx;
    logic                  hit;

    // bit 0 is always zero for legal pcs
    // so indexing starts at halfword granularity
    assign lookup_idx = btb.lookup_pc[IDX_W:1];
    assign update_idx = btb.update_pc[IDX_W:1];

    // full tag compare, no aliasing between pcs
    assign hit = valid_q[lookup_idx] && (tag_q[lookup_idx] == btb.lookup_pc);

    always_comb begin : lookup
        btb.predict = '0;
        if (hit) begin
            btb.predict.valid           = 1'b1;
            btb.predict.predict_address = target_q[lookup_idx];
            // only taken branches are ever stored
            btb.predict.predict_taken   = 1'b1;
        end
    end

    // valid bits
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= '0;
        end else if (btb.update_valid) begin
            // not taken outcome clears the slot
            valid_q[update_idx] <= btb.update_taken;
        end
    end

    // tag and target storage
    always_ff @(posedge clk_i) begin
        if (btb.update_valid && btb.update_taken) begin
            tag_q[update_idx]    <= btb.update_pc;
            target_q[update_idx] <= btb.update_target;
        end
    end

    // entries are only ever written for halfword aligned pcs
    assert property (@(posedge clk_i) disable iff (!arst_n_i)
        btb.update_valid |-> !btb.update_pc[0])
    else $error("target buffer update with odd pc");

    // a written entry is seen by the very next lookup of that pc
    assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (btb.update_valid && btb.update_taken)
        ##1 (btb.lookup_pc == $past(btb.update_pc))
        |-> btb.predict.valid)
    else $error("target buffer missed a freshly written entry");

endmodule

// ==== branch_resolve_top.sv ====
// ========================================
// branch resolution top
// branch unit with its target buffer
// ========================================

`timescale 1ns/1ps

module branch_resolve_top #(
    parameter int unsigned NR_ENTRIES = 16
) (
    input  logic                        clk_i,
    input  logic                        arst_n_i,
    input  logic                        valid_i,
    input  logic                        fu_valid_i,
    input  branch_pkg::fu_op            operator_i,
    input  logic [branch_pkg::XLEN-1:0] imm_i,
    input  logic [branch_pkg::XLEN-1:0] pc_i,
    input  logic [branch_pkg::XLEN-1:0] operand_a_i,
    input  logic [branch_pkg::XLEN-1:0] operand_b_i,
    input  logic [branch_pkg::XLEN-1:0] operand_c_i,
    input  logic                        is_compressed_instr_i,
    // resolved branch
    output logic [branch_pkg::XLEN-1:0] resolved_pc_o,
    output logic [branch_pkg::XLEN-1:0] resolved_target_o,
    output logic                        is_taken_o,
    output logic                        is_mispredict_o,
    output logic                        is_lower_16_o,
    output logic                        resolve_branch_o,
    // misaligned target exception
    output logic                        ex_valid_o,
    output logic [branch_pkg::XLEN-1:0] ex_cause_o,
    output logic [branch_pkg::XLEN-1:0] ex_tval_o
);

    branch_pkg::branchpredict resolved_branch;
    branch_pkg::exception     branch_ex;

    btb_if btb ();

    branch_unit i_branch_unit (
        .clk_i                 (clk_i),
        .operator_i            (operator_i),
        .operand_a_i           (operand_a_i),
        .operand_b_i           (operand_b_i),
        .operand_c_i           (operand_c_i),
        .imm_i                 (imm_i),
        .pc_i                  (pc_i),
        .is_compressed_instr_i (is_compressed_instr_i),
        .fu_valid_i            (fu_valid_i),
        .valid_i               (valid_i),
        .resolved_branch_o     (resolved_branch),
        .resolve_branch_o      (resolve_branch_o),
        .branch_ex_o           (branch_ex),
        .btb                   (btb.unit)
    );

    branch_target_buffer #(
        .NR_ENTRIES (NR_ENTRIES)
    ) i_branch_target_buffer (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .btb      (btb.buffer)
    );

    // flatten structs onto the plain ports
    assign resolved_pc_o     = resolved_branch.pc;
    assign resolved_target_o = resolved_branch.target_address;
    assign is_taken_o        = resolved_branch.is_taken;
    assign is_mispredict_o   = resolved_branch.is_mispredict;
    assign is_lower_16_o     = resolved_branch.is_lower_16;

    assign ex_valid_o = branch_ex.valid;
    assign ex_cause_o = branch_ex.cause;
    assign ex_tval_o  = branch_ex.tval;

endmodule

// ==== tb_branch_resolve.sv ====
// ========================================
// branch resolution testbench
// directed and lfsr branches vs a table model
// ========================================

`timescale 1ns/1ps

module tb_branch_resolve;

    localparam int unsigned XLEN       = branch_pkg::XLEN;
    localparam int unsigned NR_ENTRIES = 16;
    localparam int unsigned IDX_W      = $clog2(NR_ENTRIES);
    localparam int          N_RANDOM   = 400;
    // directed cycles including reset, rounded up
    localparam int          N_DIRECTED = 80;
    localparam int          TIMEOUT_NS = (N_RANDOM + N_DIRECTED + 50) * 20;
    localparam logic [XLEN-1:0] P_PC   = 64'h4010;
    // uncompressed branch on halfword 1
    localparam logic [XLEN-1:0] Q_PC   = 64'h4022;

    logic                    clk_i = 1'b0;
    logic                    arst_n_i;
    logic                    valid_i;
    logic                    fu_valid_i;
    branch_pkg::fu_op        operator_i;
    logic [XLEN-1:0]         imm_i, pc_i, operand_a_i, operand_b_i, operand_c_i;
    logic                    is_compressed_instr_i;
    logic [XLEN-1:0]         resolved_pc_o, resolved_target_o, ex_cause_o, ex_tval_o;
    logic                    is_taken_o, is_mispredict_o, is_lower_16_o;
    logic                    resolve_branch_o, ex_valid_o;

    int                      errors = 0;
    int                      cycles = 0;
    logic [31:0]             lfsr_state = 32'h93ec;

    // reference copy of the target buffer
    logic [NR_ENTRIES-1:0]   model_valid;
    logic [XLEN-1:0]         model_tag    [NR_ENTRIES];
    logic [XLEN-1:0]         model_target [NR_ENTRIES];

    logic                    cond_taken, model_hit, exp_taken, exp_mispredict;
    logic                    exp_lower16, exp_ex_valid;
    logic [XLEN-1:0]         exp_tgt, exp_fall, exp_adj, look_pc, exp_pred_addr, exp_target;
    logic [IDX_W-1:0]        look_idx;

    branch_resolve_top #(
        .NR_ENTRIES (NR_ENTRIES)
    ) UUT (.*);

    always #10 clk_i = ~clk_i;

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [XLEN-1:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[XLEN-2:0], lfsr_state[0]};
        end
    endtask

    function automatic logic branch_taken(input branch_pkg::fu_op op,
                                          input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
        case (op)
            branch_pkg::EQ:  return a == b;
            branch_pkg::NE:  return a != b;
            branch_pkg::LTS: return $signed(a) < $signed(b);
            branch_pkg::GES: return $signed(a) >= $signed(b);
            branch_pkg::LTU: return a < b;
            branch_pkg::GEU: return a >= b;
            default:         return 1'b1;
        endcase
    endfunction

    // expected outcome for the inputs of this cycle
    assign cond_taken  = branch_taken(operator_i, operand_a_i, operand_b_i);
    assign exp_tgt     = operand_c_i + imm_i;
    assign exp_fall    = is_compressed_instr_i ? pc_i + 64'd2 : pc_i + 64'd4;
    assign exp_adj     = (!is_compressed_instr_i && pc_i[1]) ? (pc_i & ~64'd3) + 64'd4 : pc_i;
    assign exp_lower16 = is_compressed_instr_i ^ pc_i[1];
    assign look_pc     = valid_i ? exp_adj : pc_i;
    assign look_idx    = look_pc[IDX_W:1];
    // only taken branches live in the table, so a hit predicts taken
    assign model_hit     = model_valid[look_idx] && (model_tag[look_idx] == look_pc);
    assign exp_pred_addr = model_hit ? model_target[look_idx] : '0;
    assign exp_taken     = valid_i && cond_taken;
    assign exp_ex_valid  = valid_i && exp_tgt[0];
    assign exp_mispredict = valid_i ? (!exp_tgt[0] && (!model_hit || !cond_taken ||
                                                      exp_pred_addr != exp_tgt))
                                    : (fu_valid_i && model_hit);
    assign exp_target = (valid_i && cond_taken) ? exp_tgt : exp_fall;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            model_valid <= '0;
        end else if (exp_mispredict) begin
            model_valid[look_idx] <= exp_taken;
            if (exp_taken) begin
                model_tag[look_idx]    <= look_pc;
                model_target[look_idx] <= exp_tgt;
            end
        end
    end

    task automatic log_mismatch(input string field, input logic [XLEN-1:0] got,
                                input logic [XLEN-1:0] want);
        errors++;
        $display("mismatch at %0t: %s is %h, expected %h", $time, field, got, want);
    endtask

    // outputs are settled half a cycle after the inputs change
    assert property (@(negedge clk_i) is_taken_o == exp_taken)
    else log_mismatch("is_taken_o", is_taken_o, exp_taken);
    assert property (@(negedge clk_i) is_mispredict_o == exp_mispredict)
    else log_mismatch("is_mispredict_o", is_mispredict_o, exp_mispredict);
    assert property (@(negedge clk_i) resolve_branch_o == valid_i)
    else log_mismatch("resolve_branch_o", resolve_branch_o, valid_i);
    assert property (@(negedge clk_i) ex_valid_o == exp_ex_valid)
    else log_mismatch("ex_valid_o", ex_valid_o, exp_ex_valid);
    assert property (@(negedge clk_i) exp_ex_valid |-> ex_cause_o == 64'd0)
    else log_mismatch("ex_cause_o", ex_cause_o, 64'd0);
    assert property (@(negedge clk_i) exp_ex_valid |-> ex_tval_o == pc_i)
    else log_mismatch("ex_tval_o", ex_tval_o, pc_i);
    assert property (@(negedge clk_i) valid_i |-> resolved_pc_o == exp_adj)
    else log_mismatch("resolved_pc_o", resolved_pc_o, exp_adj);
    assert property (@(negedge clk_i) valid_i |-> is_lower_16_o == exp_lower16)
    else log_mismatch("is_lower_16_o", is_lower_16_o, exp_lower16);
    assert property (@(negedge clk_i) (valid_i || exp_mispredict) |->
                     resolved_target_o == exp_target)
    else log_mismatch("resolved_target_o", resolved_target_o, exp_target);
    // idle cycles, reset included, produce nothing
    assert property (@(negedge clk_i) (!valid_i && !fu_valid_i) |->
                     !(resolve_branch_o || is_mispredict_o || ex_valid_o))
    else log_mismatch("idle strobes", {resolve_branch_o, is_mispredict_o, ex_valid_o}, 64'd0);

    task automatic drive(input branch_pkg::fu_op op, input logic [XLEN-1:0] a,
                         input logic [XLEN-1:0] b, input logic [XLEN-1:0] c,
                         input logic [XLEN-1:0] imm, input logic [XLEN-1:0] pc,
                         input logic comp, input logic vld, input logic fu_vld);
        @(posedge clk_i);
        #2;
        operator_i            = op;
        operand_a_i           = a;
        operand_b_i           = b;
        operand_c_i           = c;
        imm_i                 = imm;
        pc_i                  = pc;
        is_compressed_instr_i = comp;
        valid_i               = vld;
        fu_valid_i            = fu_vld;
        cycles++;
    endtask

    task automatic idle(input int n);
        repeat (n) drive(branch_pkg::EQ, '0, '0, '0, '0, '0, 1'b0, 1'b0, 1'b0);
    endtask

    // pc relative branch, direction set through EQ or NE on equal operands
    task automatic branch(input logic [XLEN-1:0] pc, input logic comp, input logic taken,
                          input logic [XLEN-1:0] target);
        drive(taken ? branch_pkg::EQ : branch_pkg::NE, 64'd5, 64'd5, pc, target - pc, pc,
              comp, 1'b1, 1'b0);
    endtask

    task automatic random_branch();
        logic [XLEN-1:0] r, a, b, c, imm, pc;
        logic [2:0]      op;
        take_bits(3, r);
        op = r[2:0];
        take_bits(64, a);
        take_bits(2, r);
        // equal and sign-bit operand pairs show up often
        case (r[1:0])
            2'd0:    take_bits(64, b);
            2'd1:    b = a;
            2'd2:    b = a ^ {1'b1, 63'd0};
            default: b = ~a;
        endcase
        take_bits(12, r);
        pc = 64'h1_0000 + {r[11:1], 1'b0};
        take_bits(16, r);
        imm = {{48{r[15]}}, r[15:1], 1'b0};
        take_bits(3, r);
        // roughly one in eight targets is odd
        imm[0] = (r[2:0] == 3'd0);
        c = (r[1:0] == 2'd1) ? 64'hffff_ffff_0000_0000 : pc;
        take_bits(3, r);
        drive(branch_pkg::fu_op'(op), a, b, c, imm, pc, r[0], r[2] | r[1], r[1]);
    endtask

    initial begin
        arst_n_i              = 1'b0;
        valid_i               = 1'b0;
        fu_valid_i            = 1'b0;
        operator_i            = branch_pkg::EQ;
        imm_i                 = '0;
        pc_i                  = '0;
        operand_a_i           = '0;
        operand_b_i           = '0;
        operand_c_i           = '0;
        is_compressed_instr_i = 1'b0;
        repeat (4) @(posedge clk_i);
        #2 arst_n_i = 1'b1;
        idle(2);
        // every operator on equal and sign-split operands
        for (int op = 0; op < 8; op++) begin
            drive(branch_pkg::fu_op'(op), 64'h1234, 64'h1234, 64'h800, 64'h40,
                  64'h1000 + op * 8, 1'b0, 1'b1, 1'b0);
            drive(branch_pkg::fu_op'(op), {1'b1, 63'd0}, 64'd1, 64'h800, 64'h40,
                  64'h1100 + op * 8, 1'b0, 1'b1, 1'b0);
            drive(branch_pkg::fu_op'(op), 64'd1, {1'b1, 63'd0}, 64'h800, 64'h40,
                  64'h1200 + op * 8, 1'b0, 1'b1, 1'b0);
        end
        // both halfwords, both lengths
        for (int k = 0; k < 4; k++) begin
            drive(branch_pkg::JALR, '0, '0, 64'h3000, 64'h10, 64'h2000 + k[1] * 2, k[0],
                  1'b1, 1'b0);
        end
        // learn a taken branch, flip it to not taken, learn it again
        branch(P_PC, 1'b0, 1'b1, P_PC + 64'h100);
        idle(3);
        branch(P_PC, 1'b0, 1'b1, P_PC + 64'h100);
        branch(P_PC, 1'b0, 1'b0, P_PC + 64'h100);
        branch(P_PC, 1'b0, 1'b0, P_PC + 64'h100);
        branch(P_PC, 1'b0, 1'b1, P_PC + 64'h100);
        idle(2);
        branch(Q_PC, 1'b0, 1'b1, Q_PC + 64'h80);
        idle(2);
        branch(Q_PC, 1'b0, 1'b1, Q_PC + 64'h80);
        // non-branch at a learned pc drops the entry
        drive(branch_pkg::JALR, '0, '0, '0, '0, P_PC, 1'b0, 1'b0, 1'b1);
        idle(1);
        branch(P_PC, 1'b0, 1'b1, P_PC + 64'h100);
        // odd target traps and leaves the table alone
        branch(P_PC, 1'b0, 1'b1, P_PC + 64'h101);
        branch(P_PC, 1'b0, 1'b1, P_PC + 64'h100);
        idle(2);
        repeat (N_RANDOM) random_branch();
        idle(2);
        @(posedge clk_i);
        $display("%0d cycles driven, %0d errors", cycles, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("timeout: run did not finish within %0d ns", TIMEOUT_NS);
        $display("Errors found");
        $finish;
    end

endmodule

// ==== sources.f ====
branch_pkg.sv
btb_if.sv
branch_unit.sv
branch_target_buffer.sv
branch_resolve_top.sv
tb_branch_resolve.sv

// ==== Bender.yml ====
package:
  name: branch_resolve

sources:
  - branch_pkg.sv
  - btb_if.sv
  - branch_unit.sv
  - branch_target_buffer.sv
  - branch_resolve_top.sv
  - target: simulation
    files:
      - tb_branch_resolve.sv
